// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// ********************
	// sizes and register map
	// ********************

	localparam int TLB_ENTRIES   = 16;
	localparam int TLB_INDEX_W   = 4;
	localparam int PAGE_OFFSET_W = 12;

	localparam logic [4:0] REG_INDEX     = 5'h00;
	localparam logic [4:0] REG_ENTRY_HI  = 5'h04;
	localparam logic [4:0] REG_ENTRY_LO0 = 5'h08;
	localparam logic [4:0] REG_ENTRY_LO1 = 5'h0c;
	localparam logic [4:0] REG_COMMAND   = 5'h10;

	// ********************
	// plain vector types
	// ********************

	typedef logic [31:0]            word_t;
	typedef logic [31:0]            virt_addr_t;
	typedef logic [31:0]            phys_addr_t;
	typedef logic [7:0]             asid_t;
	typedef logic [18:0]            vpn2_t;      // vaddr 31..13, one pair of pages
	typedef logic [19:0]            pfn_t;
	typedef logic [TLB_INDEX_W-1:0] tlb_index_t;
	typedef logic [4:0]             apb_addr_t;

	// ********************
	// bundles
	// ********************

	typedef struct packed {
		pfn_t pfn;
		logic dirty;                             // set when the page is writable
		logic valid;
	} tlb_page_t;

	typedef struct packed {
		vpn2_t     vpn2;
		asid_t     asid;
		logic      is_global;                    // ignore asid on match
		tlb_page_t page0;                        // even page, vaddr bit 12 clear
		tlb_page_t page1;
	} tlb_entry_t;

	typedef struct packed {
		phys_addr_t phys_addr;
		logic       miss;
		logic       valid;
		logic       dirty;
	} tlb_result_t;

	typedef struct packed {
		phys_addr_t phy_addr;
		virt_addr_t virt_addr;
		logic       miss;
		logic       invalid;
		logic       illegal;
		logic       dirty;
	} mmu_result_t;

	typedef struct packed {
		apb_addr_t paddr;
		logic      psel;
		logic      penable;
		logic      pwrite;
		word_t     pwdata;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_TLBR  = 2'd1,
		CMD_TLBWI = 2'd2,
		CMD_TLBP  = 2'd3
	} tlb_cmd_e;

endpackage

`default_nettype wire

// ==== mmu/tlb.sv ====
`default_nettype none

module tlb import cpu_pkg::*; (
	input  wire              clk,
	input  wire              rst,
	input  wire asid_t       asid,
	input  wire virt_addr_t  inst_vaddr,
	input  wire virt_addr_t  data_vaddr,

	output tlb_result_t      inst_result,
	output tlb_result_t      data_result,

	input  wire tlb_index_t  tlbrw_index,
	input  wire              tlbrw_we,
	input  wire tlb_entry_t  tlbrw_wdata,
	output tlb_entry_t       tlbrw_rdata,

	input  wire word_t       tlbp_entry_hi,
	output word_t            tlbp_index
);

	tlb_entry_t entries [TLB_ENTRIES];

	logic [TLB_ENTRIES-1:0] inst_match;
	logic [TLB_ENTRIES-1:0] data_match;
	logic [TLB_ENTRIES-1:0] probe_match;

	vpn2_t inst_vpn2, data_vpn2, probe_vpn2;
	asid_t probe_asid;

	// ********************
	// entry storage
	// ********************

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < TLB_ENTRIES; i++)
				entries[i] <= '0;
		end
		else if (tlbrw_we)
		begin
			entries[tlbrw_index] <= tlbrw_wdata;
		end
	end

	assign tlbrw_rdata = entries[tlbrw_index];

	// ********************
	// match networks
	// ********************

	function automatic logic entry_hit(
		input tlb_entry_t e,
		input vpn2_t      vpn2,
		input asid_t      cur_asid
	);
		return (e.vpn2 == vpn2) && (e.is_global || e.asid == cur_asid);
	endfunction

	assign inst_vpn2  = inst_vaddr[31:PAGE_OFFSET_W+1];
	assign data_vpn2  = data_vaddr[31:PAGE_OFFSET_W+1];
	assign probe_vpn2 = tlbp_entry_hi[31:PAGE_OFFSET_W+1];
	assign probe_asid = tlbp_entry_hi[7:0];                 // probe uses the asid in entry_hi

	always_comb
	begin
		for (int i = 0; i < TLB_ENTRIES; i++)
		begin
			inst_match[i]  = entry_hit(entries[i], inst_vpn2, asid);
			data_match[i]  = entry_hit(entries[i], data_vpn2, asid);
			probe_match[i] = entry_hit(entries[i], probe_vpn2, probe_asid);
		end
	end

	// at most one entry matches, so the pages can simply be or-ed together
	function automatic tlb_result_t lookup(
		input logic [TLB_ENTRIES-1:0] hit,
		input virt_addr_t             vaddr
	);
		tlb_page_t   page;
		tlb_result_t res;
		page = '0;
		for (int i = 0; i < TLB_ENTRIES; i++)
		begin
			if (hit[i])
				page |= vaddr[PAGE_OFFSET_W] ? entries[i].page1 : entries[i].page0;
		end
		res.phys_addr = {page.pfn, vaddr[PAGE_OFFSET_W-1:0]};
		res.miss      = ~|hit;
		res.valid     = page.valid;
		res.dirty     = page.dirty;
		return res;
	endfunction

	assign inst_result = lookup(inst_match, inst_vaddr);
	assign data_result = lookup(data_match, data_vaddr);

	always_comb
	begin
		tlbp_index     = '0;
		tlbp_index[31] = ~|probe_match;                     // probe failure flag
		for (int i = 0; i < TLB_ENTRIES; i++)
		begin
			if (probe_match[i])
				tlbp_index[TLB_INDEX_W-1:0] |= tlb_index_t'(i);
		end
	end

endmodule

`default_nettype wire

// ==== mmu/mmu.sv ====
`default_nettype none

module mmu import cpu_pkg::*; (
	input  wire              clk,
	input  wire              rst,
	input  wire asid_t       asid,
	input  wire              is_user_mode,
	input  wire virt_addr_t  inst_vaddr,
	input  wire virt_addr_t  data_vaddr,

	output mmu_result_t      inst_result,
	output mmu_result_t      data_result,

	input  wire tlb_index_t  tlbrw_index,
	input  wire              tlbrw_we,
	input  wire tlb_entry_t  tlbrw_wdata,
	output tlb_entry_t       tlbrw_rdata,

	input  wire word_t       tlbp_entry_hi,
	output word_t            tlbp_index
);

	logic        inst_mapped, data_mapped;
	logic        user_periph;
	tlb_result_t inst_tlb, data_tlb;

	// useg, kseg2 and kseg3 go through the tlb
	function automatic logic is_mapped(input virt_addr_t vaddr);
		return ~vaddr[31] || (vaddr[31:30] == 2'b11);
	endfunction

	assign inst_mapped = is_mapped(inst_vaddr);
	assign data_mapped = is_mapped(data_vaddr);

	assign user_periph = (data_vaddr[31:24] >= 8'ha2) && (data_vaddr[31:24] <= 8'ha7);

	// ********************
	// instruction path
	// ********************

	assign inst_result.phy_addr  = inst_mapped ? inst_tlb.phys_addr : {3'b000, inst_vaddr[28:0]};
	assign inst_result.virt_addr = inst_vaddr;
	assign inst_result.miss      = inst_mapped & inst_tlb.miss;
	assign inst_result.invalid   = inst_mapped & ~inst_tlb.valid;
	assign inst_result.illegal   = is_user_mode & inst_vaddr[31];
	assign inst_result.dirty     = 1'b0;                   // fetches never write

	// ********************
	// data path
	// ********************

	assign data_result.phy_addr  = data_mapped ? data_tlb.phys_addr : {3'b000, data_vaddr[28:0]};
	assign data_result.virt_addr = data_vaddr;
	assign data_result.miss      = data_mapped & data_tlb.miss;
	assign data_result.invalid   = data_mapped & ~data_tlb.valid;
	assign data_result.illegal   = is_user_mode & data_vaddr[31] & ~user_periph;
	assign data_result.dirty     = ~data_mapped | data_tlb.dirty;   // unmapped is always writable

	tlb tlb_inst (
		.clk,
		.rst,
		.asid,
		.inst_vaddr,
		.data_vaddr,
		.inst_result (inst_tlb),
		.data_result (data_tlb),
		.tlbrw_index,
		.tlbrw_we,
		.tlbrw_wdata,
		.tlbrw_rdata,
		.tlbp_entry_hi,
		.tlbp_index
	);

endmodule

`default_nettype wire

// ==== logic/tlb_regs.sv ====
`default_nettype none

module tlb_regs import cpu_pkg::*; (
	input  wire              clk,
	input  wire              rst,
	input  wire apb_req_t    apb_req,
	output apb_rsp_t         apb_rsp,

	output asid_t            asid,
	output tlb_index_t       tlbrw_index,
	output logic             tlbrw_we,
	output tlb_entry_t       tlbrw_wdata,
	input  wire tlb_entry_t  tlbrw_rdata,
	output word_t            tlbp_entry_hi,
	input  wire word_t       tlbp_index
);

	tlb_index_t idx;
	logic       probe_fail;
	vpn2_t      hi_vpn2;
	asid_t      hi_asid;
	tlb_page_t  lo0_page, lo1_page;
	logic       lo0_g, lo1_g;

	logic      access, wr, addr_ok, cmd_wr;
	tlb_cmd_e  cmd;
	word_t     entry_hi_word;

	function automatic word_t lo_word(input tlb_page_t page, input logic g);
		return {6'b0, page.pfn, 3'b0, page.dirty, page.valid, g};
	endfunction

	assign access  = apb_req.psel & apb_req.penable;
	assign wr      = access & apb_req.pwrite;
	assign addr_ok = apb_req.paddr inside {REG_INDEX, REG_ENTRY_HI, REG_ENTRY_LO0,
		REG_ENTRY_LO1, REG_COMMAND};
	assign cmd     = tlb_cmd_e'(apb_req.pwdata[1:0]);
	assign cmd_wr  = wr & (apb_req.paddr == REG_COMMAND);

	assign entry_hi_word = {hi_vpn2, 5'b0, hi_asid};

	// ********************
	// register file
	// ********************

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			idx        <= '0;
			probe_fail <= 1'b0;
			hi_vpn2    <= '0;
			hi_asid    <= '0;
			lo0_page   <= '0;
			lo1_page   <= '0;
			lo0_g      <= 1'b0;
			lo1_g      <= 1'b0;
		end
		else if (wr)
		begin
			case (apb_req.paddr)
				REG_INDEX:
				begin
					idx        <= apb_req.pwdata[TLB_INDEX_W-1:0];
					probe_fail <= apb_req.pwdata[31];
				end
				REG_ENTRY_HI:
				begin
					hi_vpn2 <= apb_req.pwdata[31:13];
					hi_asid <= apb_req.pwdata[7:0];
				end
				REG_ENTRY_LO0:
				begin
					lo0_page <= {apb_req.pwdata[25:6], apb_req.pwdata[2], apb_req.pwdata[1]};
					lo0_g    <= apb_req.pwdata[0];
				end
				REG_ENTRY_LO1:
				begin
					lo1_page <= {apb_req.pwdata[25:6], apb_req.pwdata[2], apb_req.pwdata[1]};
					lo1_g    <= apb_req.pwdata[0];
				end
				REG_COMMAND:
				begin
					if (cmd == CMD_TLBR)
					begin
						hi_vpn2  <= tlbrw_rdata.vpn2;
						hi_asid  <= tlbrw_rdata.asid;
						lo0_page <= tlbrw_rdata.page0;
						lo1_page <= tlbrw_rdata.page1;
						lo0_g    <= tlbrw_rdata.is_global;
						lo1_g    <= tlbrw_rdata.is_global;
					end
					else if (cmd == CMD_TLBP)
					begin
						idx        <= tlbp_index[TLB_INDEX_W-1:0];
						probe_fail <= tlbp_index[31];
					end
				end
				default:
				begin
				end
			endcase
		end
	end

	// ********************
	// tlb side and read mux
	// ********************

	assign asid          = hi_asid;
	assign tlbrw_index   = idx;
	assign tlbrw_we      = cmd_wr & (cmd == CMD_TLBWI);     // high only in the access cycle
	assign tlbrw_wdata   = {hi_vpn2, hi_asid, lo0_g & lo1_g, lo0_page, lo1_page};
	assign tlbp_entry_hi = entry_hi_word;

	always_comb
	begin
		apb_rsp.prdata = '0;                                 // command and unknown read 0
		case (apb_req.paddr)
			REG_INDEX:     apb_rsp.prdata = {probe_fail, {(31 - TLB_INDEX_W){1'b0}}, idx};
			REG_ENTRY_HI:  apb_rsp.prdata = entry_hi_word;
			REG_ENTRY_LO0: apb_rsp.prdata = lo_word(lo0_page, lo0_g);
			REG_ENTRY_LO1: apb_rsp.prdata = lo_word(lo1_page, lo1_g);
			default:       apb_rsp.prdata = '0;
		endcase
		apb_rsp.pready  = 1'b1;                              // no wait states
		apb_rsp.pslverr = access & ~addr_ok;
	end

endmodule

`default_nettype wire

// ==== logic/mmu_top.sv ====
`default_nettype none

module mmu_top import cpu_pkg::*; (
	input  wire              clk,
	input  wire              rst,
	input  wire apb_req_t    apb_req,
	output apb_rsp_t         apb_rsp,
	input  wire              is_user_mode,
	input  wire virt_addr_t  inst_vaddr,
	input  wire virt_addr_t  data_vaddr,
	output mmu_result_t      inst_result,
	output mmu_result_t      data_result
);

	asid_t      asid;
	tlb_index_t tlbrw_index;
	logic       tlbrw_we;
	tlb_entry_t tlbrw_wdata, tlbrw_rdata;
	word_t      tlbp_entry_hi, tlbp_index;

	tlb_regs regs_inst (
		.clk,
		.rst,
		.apb_req,
		.apb_rsp,
		.asid,
		.tlbrw_index,
		.tlbrw_we,
		.tlbrw_wdata,
		.tlbrw_rdata,
		.tlbp_entry_hi,
		.tlbp_index
	);

	mmu mmu_inst (
		.clk,
		.rst,
		.asid,
		.is_user_mode,
		.inst_vaddr,
		.data_vaddr,
		.inst_result,
		.data_result,
		.tlbrw_index,
		.tlbrw_we,
		.tlbrw_wdata,
		.tlbrw_rdata,
		.tlbp_entry_hi,
		.tlbp_index
	);

endmodule

`default_nettype wire

// ==== test/tb_mmu.sv ====
`default_nettype none

module tb_mmu import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [1:0] {ROW_WRITE, ROW_READ, ROW_XLATE} row_kind_e;

	typedef struct packed {
		row_kind_e   kind;
		apb_addr_t   addr;
		word_t       wdata;
		word_t       exp_rdata;
		logic        exp_slverr;
		logic        user;
		virt_addr_t  inst_vaddr;
		virt_addr_t  data_vaddr;
		mmu_result_t exp_inst;
		mmu_result_t exp_data;
	} row_t;

	// result flags in the order miss, invalid, illegal, dirty
	localparam logic [3:0] F_MISS  = 4'b1000;
	localparam logic [3:0] F_INV   = 4'b0100;
	localparam logic [3:0] F_ILL   = 4'b0010;
	localparam logic [3:0] F_DIRTY = 4'b0001;

	localparam word_t HI_MASK    = 32'hffff_e0ff;
	localparam word_t LO_MASK    = 32'h03ff_ffc7;
	localparam word_t INDEX_MASK = 32'h8000_000f;

	localparam vpn2_t VPN_A    = 19'h00200;           // useg page pair at 0x0040_0000
	localparam vpn2_t VPN_B    = 19'h60400;           // kseg2 page pair at 0xc080_0000
	localparam vpn2_t VPN_NONE = 19'h08000;           // never written
	localparam pfn_t  PFN_A0   = 20'h12345;
	localparam pfn_t  PFN_A1   = 20'h0abcd;
	localparam pfn_t  PFN_B0   = 20'h54321;
	localparam pfn_t  PFN_B1   = 20'h00f0f;

	logic        clk;
	logic        rst;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        is_user_mode;
	virt_addr_t  inst_vaddr;
	virt_addr_t  data_vaddr;
	mmu_result_t inst_result;
	mmu_result_t data_result;

	row_t rows[$];
	logic rows_ready;

	mmu_top dut (
		.clk,
		.rst,
		.apb_req,
		.apb_rsp,
		.is_user_mode,
		.inst_vaddr,
		.data_vaddr,
		.inst_result,
		.data_result
	);

	always #5 clk = ~clk;

	// ********************
	// checks
	// ********************

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			fail_now($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_mmu_result(input string name, input mmu_result_t got,
		input mmu_result_t exp);
		if (got !== exp)
			fail_now($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	// ********************
	// table building
	// ********************

	function automatic word_t make_hi(input vpn2_t vpn2, input asid_t asid);
		return {vpn2, 5'b0, asid};
	endfunction

	function automatic word_t make_lo(input pfn_t pfn, input logic d, input logic v, input logic g);
		return {6'b0, pfn, 3'b0, d, v, g};
	endfunction

	function automatic phys_addr_t frame_base(input pfn_t pfn);
		return {pfn, 12'h000};
	endfunction

	function automatic mmu_result_t expect_result(input virt_addr_t va, input phys_addr_t pa,
		input logic [3:0] fl);
		mmu_result_t res;
		res.phy_addr  = pa;
		res.virt_addr = va;
		res.miss      = fl[3];
		res.invalid   = fl[2];
		res.illegal   = fl[1];
		res.dirty     = fl[0];
		return res;
	endfunction

	task automatic add_write(input apb_addr_t addr, input word_t data, input logic err);
		row_t r;
		r = '0;
		r.kind       = ROW_WRITE;
		r.addr       = addr;
		r.wdata      = data;
		r.exp_slverr = err;
		rows.push_back(r);
	endtask

	task automatic add_read(input apb_addr_t addr, input word_t exp, input logic err);
		row_t r;
		r = '0;
		r.kind       = ROW_READ;
		r.addr       = addr;
		r.exp_rdata  = exp;
		r.exp_slverr = err;
		rows.push_back(r);
	endtask

	// the same random page offset goes into the vaddr and the expected address
	task automatic add_translate(input logic user,
		input virt_addr_t iva, input phys_addr_t ipa, input logic [3:0] ifl,
		input virt_addr_t dva, input phys_addr_t dpa, input logic [3:0] dfl);
		row_t       r;
		logic [11:0] oi;
		logic [11:0] od;
		oi = 12'($urandom);
		od = 12'($urandom);
		r = '0;
		r.kind       = ROW_XLATE;
		r.user       = user;
		r.inst_vaddr = iva | 32'(oi);
		r.data_vaddr = dva | 32'(od);
		r.exp_inst   = expect_result(r.inst_vaddr, ipa | 32'(oi), ifl);
		r.exp_data   = expect_result(r.data_vaddr, dpa | 32'(od), dfl);
		rows.push_back(r);
	endtask

	task automatic build_table();
		// register access and decode errors
		add_write(REG_ENTRY_HI, 32'hffff_ffff, 1'b0);
		add_read(REG_ENTRY_HI, 32'hffff_ffff & HI_MASK, 1'b0);
		add_write(REG_ENTRY_LO0, 32'hffff_ffff, 1'b0);
		add_read(REG_ENTRY_LO0, 32'hffff_ffff & LO_MASK, 1'b0);
		add_write(REG_ENTRY_LO1, 32'ha5a5_a5a5, 1'b0);
		add_read(REG_ENTRY_LO1, 32'ha5a5_a5a5 & LO_MASK, 1'b0);
		add_write(REG_INDEX, 32'hffff_ffff, 1'b0);
		add_read(REG_INDEX, 32'hffff_ffff & INDEX_MASK, 1'b0);
		add_write(5'h14, 32'h1234_5678, 1'b1);
		add_read(5'h14, 32'h0, 1'b1);
		add_read(REG_COMMAND, 32'h0, 1'b0);
		add_read(REG_ENTRY_HI, 32'hffff_ffff & HI_MASK, 1'b0);

		// TLBWI to entry 5, clobber the registers, TLBR it back
		add_write(REG_ENTRY_HI, make_hi(VPN_A, 8'h11), 1'b0);
		add_write(REG_ENTRY_LO0, make_lo(PFN_A0, 1'b1, 1'b1, 1'b1), 1'b0);
		add_write(REG_ENTRY_LO1, make_lo(PFN_A1, 1'b0, 1'b1, 1'b0), 1'b0);
		add_write(REG_INDEX, 32'd5, 1'b0);
		add_write(REG_COMMAND, 32'(CMD_TLBWI), 1'b0);
		add_write(REG_ENTRY_HI, make_hi(19'h12345, 8'h22), 1'b0);
		add_write(REG_ENTRY_LO0, make_lo(20'h00000, 1'b0, 1'b0, 1'b1), 1'b0);
		add_write(REG_ENTRY_LO1, make_lo(20'hfffff, 1'b1, 1'b1, 1'b1), 1'b0);
		add_write(REG_COMMAND, 32'(CMD_TLBR), 1'b0);
		add_read(REG_ENTRY_HI, make_hi(VPN_A, 8'h11), 1'b0);
		add_read(REG_ENTRY_LO0, make_lo(PFN_A0, 1'b1, 1'b1, 1'b0), 1'b0);
		add_read(REG_ENTRY_LO1, make_lo(PFN_A1, 1'b0, 1'b1, 1'b0), 1'b0);
		add_read(REG_INDEX, 32'd5, 1'b0);

		// global kseg2 entry 7 with its odd page left invalid
		add_write(REG_ENTRY_HI, make_hi(VPN_B, 8'h33), 1'b0);
		add_write(REG_ENTRY_LO0, make_lo(PFN_B0, 1'b0, 1'b1, 1'b1), 1'b0);
		add_write(REG_ENTRY_LO1, make_lo(PFN_B1, 1'b1, 1'b0, 1'b1), 1'b0);
		add_write(REG_INDEX, 32'd7, 1'b0);
		add_write(REG_COMMAND, 32'(CMD_TLBWI), 1'b0);
		add_write(REG_ENTRY_HI, make_hi(VPN_A, 8'h11), 1'b0);

		// mapped hits under asid 0x11
		add_translate(1'b0, 32'h0040_0000, frame_base(PFN_A0), 4'b0,
			32'h0040_1000, frame_base(PFN_A1), 4'b0);
		add_translate(1'b0, 32'h0040_1000, frame_base(PFN_A1), 4'b0,
			32'h0040_0000, frame_base(PFN_A0), F_DIRTY);
		add_translate(1'b0, 32'hc080_0000, frame_base(PFN_B0), 4'b0,
			32'hc080_0000, frame_base(PFN_B0), 4'b0);

		// a miss finds no page, so the frame reads as zero
		add_translate(1'b0, 32'h1000_0000, 32'h0, F_MISS | F_INV,
			32'hc080_1000, frame_base(PFN_B1), F_INV | F_DIRTY);
		add_write(REG_ENTRY_HI, make_hi(VPN_A, 8'h44), 1'b0);
		add_translate(1'b0, 32'h0040_0000, 32'h0, F_MISS | F_INV,
			32'hc080_0000, frame_base(PFN_B0), 4'b0);
		add_translate(1'b0, 32'hc080_1000, frame_base(PFN_B1), F_INV,
			32'h0040_1000, 32'h0, F_MISS | F_INV);
		add_write(REG_ENTRY_HI, make_hi(VPN_A, 8'h11), 1'b0);

		// unmapped segments and user mode
		add_translate(1'b0, 32'h8012_3000, 32'h0012_3000, 4'b0,
			32'ha034_5000, 32'h0034_5000, F_DIRTY);
		add_translate(1'b1, 32'h8000_0000, 32'h0000_0000, F_ILL,
			32'ha200_0000, 32'h0200_0000, F_DIRTY);
		add_translate(1'b1, 32'ha7ff_f000, 32'h07ff_f000, F_ILL,
			32'ha7ff_f000, 32'h07ff_f000, F_DIRTY);
		add_translate(1'b1, 32'hc080_0000, frame_base(PFN_B0), F_ILL,
			32'ha1ff_f000, 32'h01ff_f000, F_ILL | F_DIRTY);
		add_translate(1'b1, 32'h0040_0000, frame_base(PFN_A0), 4'b0,
			32'ha800_0000, 32'h0800_0000, F_ILL | F_DIRTY);
		add_translate(1'b1, 32'h0040_1000, frame_base(PFN_A1), 4'b0,
			32'hc080_1000, frame_base(PFN_B1), F_ILL | F_INV | F_DIRTY);

		// probe a miss first so bit 31 is seen to clear on a hit
		add_write(REG_ENTRY_HI, make_hi(VPN_NONE, 8'h11), 1'b0);
		add_write(REG_COMMAND, 32'(CMD_TLBP), 1'b0);
		add_read(REG_INDEX, 32'h8000_0000, 1'b0);
		add_write(REG_ENTRY_HI, make_hi(VPN_A, 8'h11), 1'b0);
		add_write(REG_COMMAND, 32'(CMD_TLBP), 1'b0);
		add_read(REG_INDEX, 32'd5, 1'b0);
		add_write(REG_ENTRY_HI, make_hi(VPN_B, 8'h99), 1'b0);
		add_write(REG_COMMAND, 32'(CMD_TLBP), 1'b0);
		add_read(REG_INDEX, 32'd7, 1'b0);
		add_write(REG_ENTRY_HI, make_hi(VPN_A, 8'h44), 1'b0);
		add_write(REG_COMMAND, 32'(CMD_TLBP), 1'b0);
		add_read(REG_INDEX, 32'h8000_0000, 1'b0);
	endtask

	// ********************
	// row drivers
	// ********************

	task automatic apply_apb(input row_t r, input int n);
		apb_req.paddr   = r.addr;
		apb_req.pwrite  = (r.kind == ROW_WRITE);
		apb_req.pwdata  = r.wdata;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		#1;
		check_bit($sformatf("row %0d pready", n), apb_rsp.pready, 1'b1);
		check_bit($sformatf("row %0d pslverr", n), apb_rsp.pslverr, r.exp_slverr);
		if (r.kind == ROW_READ)
			check_word($sformatf("row %0d prdata", n), apb_rsp.prdata, r.exp_rdata);
		@(posedge clk);
		#1;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apply_translate(input row_t r, input int n);
		is_user_mode = r.user;
		inst_vaddr   = r.inst_vaddr;
		data_vaddr   = r.data_vaddr;
		#1;
		check_mmu_result($sformatf("row %0d inst_result", n), inst_result, r.exp_inst);
		check_mmu_result($sformatf("row %0d data_result", n), data_result, r.exp_data);
		@(posedge clk);
		#1;
	endtask

	initial
	begin
		wait (rows_ready);
		repeat (rows.size() * 4 + 100) @(posedge clk);
		fail_now("timeout: the stimulus table did not finish in time");
	end

	initial
	begin
		clk          = 1'b0;
		rst          = 1'b1;
		apb_req      = '0;
		is_user_mode = 1'b0;
		inst_vaddr   = '0;
		data_vaddr   = '0;
		rows_ready   = 1'b0;
		void'($urandom(3));
		build_table();
		rows_ready = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		foreach (rows[i])
		begin
			if (rows[i].kind == ROW_XLATE)
				apply_translate(rows[i], i);
			else
				apply_apb(rows[i], i);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
common/cpu_pkg.sv
mmu/tlb.sv
mmu/mmu.sv
logic/tlb_regs.sv
logic/mmu_top.sv
test/tb_mmu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the MMU testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_mmu -f compile.f --Mdir obj_dir

# the simulator exits nonzero on a failure, so keep going and judge by the log
./obj_dir/Vtb_mmu 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi

grep -q "TB PASSED" sim.log
echo "simulation passed"
